// File: hdl/desc_csr.sv
/*
  host register block: control fields, start location, registered
  readback and the interrupt status with its masked irq output
*/
`default_nettype none

module desc_csr (
  input wire clk,
  input wire reset,
  input wire desc_frontend_pkg::csr_reg_t s_address,
  input wire s_read,
  input wire s_write,
  input wire [desc_frontend_pkg::csr_data_width-1:0] s_writedata,
  input wire [7:0] s_byteenable,
  input wire [desc_frontend_pkg::addr_width-1:0] fetch_location,
  input wire [desc_frontend_pkg::addr_width-1:0] store_location,
  input wire desc_frontend_pkg::fetch_state_t fetch_state,
  input wire desc_frontend_pkg::store_state_t store_state,
  input wire irq_event,
  output logic [desc_frontend_pkg::csr_data_width-1:0] s_readdata,
  output logic enable,
  output logic [desc_frontend_pkg::addr_width-1:0] start_location,
  output logic load_start,
  output logic irq
);

  import desc_frontend_pkg::*;

  // zero padding above a 48-bit address in a 64-bit register
  localparam int loc_pad = csr_data_width - addr_width;

  logic irq_mask;
  logic irq_status;
  logic wr_control;
  logic wr_start;
  logic clear_irq;
  logic fetch_idle;
  logic store_idle;

  assign wr_control = s_write && (s_address == reg_control);
  assign wr_start = s_write && (s_address == reg_start);
  // write 1 to status bit 0 clears the interrupt
  assign clear_irq = s_write && (s_address == reg_status) && s_byteenable[0] && s_writedata[0];

  assign fetch_idle = (fetch_state == f_idle);
  assign store_idle = (store_state == s_idle);

  // the host only sees the interrupt when it has unmasked it
  assign irq = irq_status && irq_mask;

  // ********************
  // write side
  // ********************

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      enable <= 1'b0;
      irq_mask <= 1'b0;
    end
    else if (wr_control && s_byteenable[0])
    begin
      enable <= s_writedata[0];
      irq_mask <= s_writedata[2];
    end
  end

  // each byte lane of the start location is written on its own
  always_ff @(posedge clk)
  begin
    for (int lane = 0; lane < addr_width / 8; lane++)
    begin
      if (wr_start && s_byteenable[lane])
      begin
        start_location[lane*8 +: 8] <= s_writedata[lane*8 +: 8];
      end
    end
  end

  // the top lane marks the end of the pointer update, so it loads both engines
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      load_start <= 1'b0;
      irq_status <= 1'b0;
    end
    else
    begin
      load_start <= wr_start && s_byteenable[7];
      // a host clear wins over a completion in the same cycle
      if (clear_irq)
      begin
        irq_status <= 1'b0;
      end
      else if (irq_event)
      begin
        irq_status <= 1'b1;
      end
    end
  end

  // ********************
  // read side
  // ********************

  always_ff @(posedge clk)
  begin
    if (s_read)
    begin
      case (s_address)
        reg_control: s_readdata <= {{(csr_data_width-3){1'b0}}, irq_mask, 1'b0, enable};
        reg_start: s_readdata <= {{loc_pad{1'b0}}, start_location};
        reg_fetch_loc: s_readdata <= {{loc_pad{1'b0}}, fetch_location};
        reg_store_loc: s_readdata <= {{loc_pad{1'b0}}, store_location};
        reg_status: s_readdata <= {{(csr_data_width-13){1'b0}}, store_state, fetch_state,
                                   5'b0, store_idle, fetch_idle, irq_status};
        default: s_readdata <= '0;
      endcase
    end
  end

  // engines load on a single edge per start write
  assert property (@(posedge clk) disable iff (reset) load_start |=> !load_start);

endmodule

`default_nettype wire

// File: hdl/desc_fetch.sv
/*
  descriptor fetch engine: one outstanding read on the fetch master
  and the dispatcher source that also pushes into the store queue
*/
`default_nettype none

module desc_fetch (
  input wire clk,
  input wire reset,
  input wire enable,
  input wire [desc_frontend_pkg::addr_width-1:0] start_location,
  input wire load_start,
  input wire m_fetch_waitrequest,
  input wire m_fetch_readdatavalid,
  input wire [desc_frontend_pkg::desc_width-1:0] m_fetch_readdata,
  input wire src_ready,
  input wire desc_queue_ready,
  output logic [desc_frontend_pkg::addr_width-1:0] m_fetch_address,
  output logic m_fetch_read,
  output logic [desc_frontend_pkg::word_width-1:0] src_source,
  output logic [desc_frontend_pkg::word_width-1:0] src_destination,
  output logic [desc_frontend_pkg::word_width-1:0] src_length,
  output logic [desc_frontend_pkg::word_width-1:0] src_control,
  output logic src_valid,
  output logic desc_push,
  output logic [desc_frontend_pkg::addr_width-1:0] desc_push_address,
  output logic [desc_frontend_pkg::addr_width-1:0] fetch_location,
  output desc_frontend_pkg::fetch_state_t fetch_state
);

  import desc_frontend_pkg::*;

  fetch_state_t state;
  logic [desc_width-1:0] desc_q;
  logic transfer;
  logic incoming_owned;

  // the descriptor goes to two sinks, so it only moves when both can take it
  assign transfer = (state == f_present) && src_ready && desc_queue_ready;
  assign src_valid = transfer;
  assign desc_push = transfer;
  // the queued address is where the store engine writes the descriptor back
  assign desc_push_address = fetch_location;

  // the location only moves outside f_request, so the address holds through waitrequest
  assign m_fetch_address = fetch_location;
  assign fetch_state = state;

  assign incoming_owned = m_fetch_readdata[ctl_lsb + owned_bit];

  assign src_source = desc_q[src_lsb +: word_width];
  assign src_destination = desc_q[dst_lsb +: word_width];
  assign src_length = desc_q[len_lsb +: word_width];
  assign src_control = desc_q[ctl_lsb +: word_width];

  // ********************
  // fetch FSM
  // ********************

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state <= f_idle;
      m_fetch_read <= 1'b0;
      fetch_location <= '0;
    end
    else
    begin
      case (state)
        f_idle:
        begin
          // sits here until the driver writes a fresh start pointer
          if (load_start)
          begin
            fetch_location <= start_location;
            state <= f_request;
          end
        end
        f_request:
        begin
          // once issued, the read is held even if enable drops
          if (m_fetch_read && !m_fetch_waitrequest)
          begin
            m_fetch_read <= 1'b0;
            state <= f_wait_data;
          end
          else if (enable)
          begin
            m_fetch_read <= 1'b1;
          end
        end
        f_wait_data:
        begin
          // an unowned descriptor ends the chain and fetch_location stays on it
          if (m_fetch_readdatavalid)
          begin
            state <= incoming_owned ? f_present : f_idle;
          end
        end
        f_present:
        begin
          if (transfer)
          begin
            fetch_location <= fetch_location + addr_width'(desc_bytes);
            state <= f_request;
          end
        end
        default: state <= f_idle;
      endcase
    end
  end

  // the captured descriptor is payload only
  always_ff @(posedge clk)
  begin
    if ((state == f_wait_data) && m_fetch_readdatavalid)
    begin
      desc_q <= m_fetch_readdata;
    end
  end

  // a stalled read keeps its request and address
  assert property (@(posedge clk) disable iff (reset)
    m_fetch_read && m_fetch_waitrequest |=> m_fetch_read);
  assert property (@(posedge clk) disable iff (reset)
    m_fetch_read && m_fetch_waitrequest |=> $stable(m_fetch_address));

endmodule

`default_nettype wire

// File: hdl/desc_frontend.sv
/*
  descriptor frontend top: register block, fetch engine and store engine
*/
`default_nettype none

module desc_frontend (
  input wire clk,
  input wire reset,
  // host register port
  input wire desc_frontend_pkg::csr_reg_t s_address,
  input wire s_read,
  output logic [desc_frontend_pkg::csr_data_width-1:0] s_readdata,
  input wire s_write,
  input wire [desc_frontend_pkg::csr_data_width-1:0] s_writedata,
  input wire [7:0] s_byteenable,
  output logic irq,
  // descriptor fetch master
  output logic [desc_frontend_pkg::addr_width-1:0] m_fetch_address,
  output logic m_fetch_read,
  input wire [desc_frontend_pkg::desc_width-1:0] m_fetch_readdata,
  input wire m_fetch_readdatavalid,
  input wire m_fetch_waitrequest,
  // descriptor writeback master
  output logic [desc_frontend_pkg::addr_width-1:0] m_store_address,
  output logic m_store_write,
  output logic [desc_frontend_pkg::desc_width-1:0] m_store_writedata,
  input wire m_store_waitrequest,
  // dispatcher source
  output logic [desc_frontend_pkg::word_width-1:0] src_source,
  output logic [desc_frontend_pkg::word_width-1:0] src_destination,
  output logic [desc_frontend_pkg::word_width-1:0] src_length,
  output logic [desc_frontend_pkg::word_width-1:0] src_control,
  output logic src_valid,
  input wire src_ready,
  // dispatcher response sink
  input wire [desc_frontend_pkg::word_width-1:0] snk_actual_bytes,
  input wire [desc_frontend_pkg::error_width-1:0] snk_error,
  input wire snk_valid,
  output logic snk_ready
);

  import desc_frontend_pkg::*;

  logic enable;
  logic [addr_width-1:0] start_location;
  logic load_start;
  logic irq_event;
  logic [addr_width-1:0] fetch_location;
  logic [addr_width-1:0] store_location;
  fetch_state_t fetch_state;
  store_state_t store_state;
  logic desc_push;
  logic [addr_width-1:0] desc_push_address;
  logic desc_queue_ready;

  desc_csr desc_csr_i (
    .clk(clk), .reset(reset),
    .s_address(s_address), .s_read(s_read), .s_write(s_write),
    .s_writedata(s_writedata), .s_byteenable(s_byteenable),
    .fetch_location(fetch_location), .store_location(store_location),
    .fetch_state(fetch_state), .store_state(store_state), .irq_event(irq_event),
    .s_readdata(s_readdata), .enable(enable), .start_location(start_location),
    .load_start(load_start), .irq(irq)
  );

  // the dispatcher and the store queue both see the fetched descriptor
  desc_fetch desc_fetch_i (
    .clk(clk), .reset(reset), .enable(enable),
    .start_location(start_location), .load_start(load_start),
    .m_fetch_waitrequest(m_fetch_waitrequest), .m_fetch_readdatavalid(m_fetch_readdatavalid),
    .m_fetch_readdata(m_fetch_readdata), .src_ready(src_ready),
    .desc_queue_ready(desc_queue_ready),
    .m_fetch_address(m_fetch_address), .m_fetch_read(m_fetch_read),
    .src_source(src_source), .src_destination(src_destination),
    .src_length(src_length), .src_control(src_control), .src_valid(src_valid),
    .desc_push(desc_push), .desc_push_address(desc_push_address),
    .fetch_location(fetch_location), .fetch_state(fetch_state)
  );

  desc_store desc_store_i (
    .clk(clk), .reset(reset),
    .start_location(start_location), .load_start(load_start),
    .desc_push(desc_push), .desc_push_address(desc_push_address),
    .src_source(src_source), .src_destination(src_destination),
    .src_length(src_length), .src_control(src_control),
    .snk_valid(snk_valid), .snk_actual_bytes(snk_actual_bytes), .snk_error(snk_error),
    .m_store_waitrequest(m_store_waitrequest),
    .desc_queue_ready(desc_queue_ready), .snk_ready(snk_ready),
    .m_store_address(m_store_address), .m_store_write(m_store_write),
    .m_store_writedata(m_store_writedata), .store_location(store_location),
    .store_state(store_state), .irq_event(irq_event)
  );

endmodule

`default_nettype wire

// File: hdl/desc_frontend_pkg.sv
/*
  shared widths, descriptor layout, host register offsets and the
  FSM state encodings of the descriptor frontend
*/
`default_nettype none

package desc_frontend_pkg;

  // ********************
  // widths
  // ********************

  // byte address width of both memory masters
  localparam int addr_width = 48;
  localparam int csr_data_width = 64;

  // a descriptor is four 32-bit words and takes one full memory word
  localparam int word_width = 32;
  localparam int desc_width = 4 * word_width;
  localparam int desc_bytes = desc_width / 8;

  // ********************
  // descriptor layout
  // ********************

  // word positions inside the 128-bit descriptor, source sits lowest
  localparam int src_lsb = 0;
  localparam int dst_lsb = 32;
  localparam int len_lsb = 64;
  localparam int ctl_lsb = 96;

  // fields inside the control word
  localparam int owned_bit = 31;
  localparam int irq_bit = 14;
  localparam int error_lsb = 0;
  localparam int error_width = 8;

  // descriptors dispatched but not yet written back
  localparam int store_queue_depth = 4;

  // ********************
  // encodings
  // ********************

  // host register offsets in 64-bit words, others read zero
  typedef enum logic [2:0] {
    reg_control = 3'd0,
    reg_start = 3'd1,
    reg_fetch_loc = 3'd2,
    reg_store_loc = 3'd3,
    reg_status = 3'd4
  } csr_reg_t;

  typedef enum logic [2:0] {
    f_idle,
    f_request,
    f_wait_data,
    f_present
  } fetch_state_t;

  typedef enum logic [1:0] {
    s_idle,
    s_write,
    s_advance
  } store_state_t;

endpackage

`default_nettype wire

// File: hdl/desc_store.sv
/*
  completion queue of dispatched descriptors and the writeback engine
  that returns each completed descriptor to the host on the write master
*/
`default_nettype none

module desc_store (
  input wire clk,
  input wire reset,
  input wire [desc_frontend_pkg::addr_width-1:0] start_location,
  input wire load_start,
  input wire desc_push,
  input wire [desc_frontend_pkg::addr_width-1:0] desc_push_address,
  input wire [desc_frontend_pkg::word_width-1:0] src_source,
  input wire [desc_frontend_pkg::word_width-1:0] src_destination,
  input wire [desc_frontend_pkg::word_width-1:0] src_length,
  input wire [desc_frontend_pkg::word_width-1:0] src_control,
  input wire snk_valid,
  input wire [desc_frontend_pkg::word_width-1:0] snk_actual_bytes,
  input wire [desc_frontend_pkg::error_width-1:0] snk_error,
  input wire m_store_waitrequest,
  output logic desc_queue_ready,
  output logic snk_ready,
  output logic [desc_frontend_pkg::addr_width-1:0] m_store_address,
  output logic m_store_write,
  output logic [desc_frontend_pkg::desc_width-1:0] m_store_writedata,
  output logic [desc_frontend_pkg::addr_width-1:0] store_location,
  output desc_frontend_pkg::store_state_t store_state,
  output logic irq_event
);

  import desc_frontend_pkg::*;

  localparam int ptr_width = $clog2(store_queue_depth);
  localparam int count_width = $clog2(store_queue_depth + 1);

  logic [desc_width-1:0] queue_desc [store_queue_depth];
  logic [addr_width-1:0] queue_addr [store_queue_depth];
  logic [ptr_width-1:0] wr_ptr;
  logic [ptr_width-1:0] rd_ptr;
  logic [count_width-1:0] count;
  store_state_t state;
  logic accept;
  logic pop;
  logic [desc_width-1:0] head_desc;
  logic [word_width-1:0] wb_control;

  // the entry under writeback stays counted until s_advance
  assign desc_queue_ready = (count != count_width'(store_queue_depth));
  assign snk_ready = (state == s_idle) && (count != '0);
  assign accept = snk_valid && snk_ready;
  assign pop = (state == s_advance);
  assign head_desc = queue_desc[rd_ptr];
  assign store_state = state;

  // hand ownership back to the host and report the error code
  always_comb
  begin
    wb_control = head_desc[ctl_lsb +: word_width];
    wb_control[owned_bit] = 1'b0;
    wb_control[error_lsb +: error_width] = snk_error;
  end

  // ********************
  // descriptor queue
  // ********************

  always_ff @(posedge clk)
  begin
    if (desc_push)
    begin
      queue_desc[wr_ptr] <= {src_control, src_length, src_destination, src_source};
      queue_addr[wr_ptr] <= desc_push_address;
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end
    else
    begin
      if (desc_push)
      begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop)
      begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (desc_push && !pop)
      begin
        count <= count + 1'b1;
      end
      else if (pop && !desc_push)
      begin
        count <= count - 1'b1;
      end
    end
  end

  // ********************
  // writeback FSM
  // ********************

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state <= s_idle;
      m_store_write <= 1'b0;
      irq_event <= 1'b0;
      store_location <= '0;
    end
    else
    begin
      irq_event <= 1'b0;
      case (state)
        s_idle:
        begin
          if (accept)
          begin
            m_store_write <= 1'b1;
            state <= s_write;
          end
        end
        s_write:
        begin
          // the interrupt request rides in the written-back control word
          if (!m_store_waitrequest)
          begin
            m_store_write <= 1'b0;
            irq_event <= m_store_writedata[ctl_lsb + irq_bit];
            state <= s_advance;
          end
        end
        s_advance:
        begin
          store_location <= m_store_address + addr_width'(desc_bytes);
          state <= s_idle;
        end
        default: state <= s_idle;
      endcase
      if (load_start)
      begin
        store_location <= start_location;
      end
    end
  end

  // the response replaces the length with the actual byte count
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      m_store_address <= queue_addr[rd_ptr];
      m_store_writedata <= {wb_control, snk_actual_bytes,
                            head_desc[dst_lsb +: word_width], head_desc[src_lsb +: word_width]};
    end
  end

  // a stalled write keeps its request and its word
  assert property (@(posedge clk) disable iff (reset)
    m_store_write && m_store_waitrequest |=> m_store_write && $stable(m_store_writedata));

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Compile and run the descriptor frontend testbench with Verilator.
# Pass or fail is taken from the simulation log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=desc_frontend_sim

verilator --binary --timing --assert -f tb.f --top-module desc_frontend_tb \
  -Mdir obj_dir -o "$BIN"
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^SIMULATION PASSED$" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1

// File: tb.f
hdl/desc_frontend_pkg.sv
hdl/desc_csr.sv
hdl/desc_fetch.sv
hdl/desc_store.sv
hdl/desc_frontend.sv
verif/desc_frontend_tb.sv

// File: verif/desc_frontend_tb.sv
/*
  testbench for the descriptor frontend: memory model for both masters,
  dispatcher model, descriptor table and register checks
*/
`default_nettype none

module desc_frontend_tb;

  import desc_frontend_pkg::*;

  localparam int n_desc = 6;
  localparam int wait_limit = 2000;
  localparam logic [addr_width-1:0] base_addr = 48'h1000;
  // word after the chain, not owned but with the irq bit set
  localparam logic [desc_width-1:0] chain_end = {32'h0000_4000, 96'h0};

  // ********************
  // descriptor table
  // ********************

  // one column per field, row i sits at base_addr + 16 * i
  logic [word_width-1:0] tbl_source [n_desc] = '{32'h0001_0000, 32'h0002_0400, 32'h0003_0080,
                                                 32'h0004_1000, 32'h0005_0010, 32'h0006_2000};
  logic [word_width-1:0] tbl_dest [n_desc] = '{32'h8000_0000, 32'h8001_0000, 32'h8002_0000,
                                               32'h8003_0000, 32'h8004_0000, 32'h8005_0000};
  logic [word_width-1:0] tbl_length [n_desc] = '{32'h100, 32'h40, 32'h1000,
                                                 32'h8, 32'h200, 32'h3fc};
  logic tbl_irq [n_desc] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0};
  logic [error_width-1:0] tbl_error [n_desc] = '{8'h00, 8'h00, 8'h11, 8'h00, 8'h80, 8'h00};
  // short transfers on the entries that report an error
  logic [word_width-1:0] tbl_actual [n_desc] = '{32'h100, 32'h40, 32'h800,
                                                 32'h8, 32'h1fc, 32'h3fc};

  logic clk = 1'b0;
  logic reset = 1'b1;
  csr_reg_t s_address = reg_control;
  logic s_read = 1'b0;
  logic [csr_data_width-1:0] s_readdata;
  logic s_write = 1'b0;
  logic [csr_data_width-1:0] s_writedata = '0;
  logic [7:0] s_byteenable = '0;
  logic irq;
  logic [addr_width-1:0] m_fetch_address;
  logic m_fetch_read;
  logic [desc_width-1:0] m_fetch_readdata = '0;
  logic m_fetch_readdatavalid = 1'b0;
  logic m_fetch_waitrequest = 1'b0;
  logic [addr_width-1:0] m_store_address;
  logic m_store_write;
  logic [desc_width-1:0] m_store_writedata;
  logic m_store_waitrequest = 1'b0;
  logic [word_width-1:0] src_source;
  logic [word_width-1:0] src_destination;
  logic [word_width-1:0] src_length;
  logic [word_width-1:0] src_control;
  logic src_valid;
  logic src_ready = 1'b0;
  logic [word_width-1:0] snk_actual_bytes = '0;
  logic [error_width-1:0] snk_error = '0;
  logic snk_valid = 1'b0;
  logic snk_ready;

  // sparse host memory keyed by byte address, one descriptor per entry
  logic [desc_width-1:0] mem [logic [addr_width-1:0]];
  logic [31:0] lcg_state = 32'hd84c;
  logic stall_en = 1'b0;
  int wb_count = 0;
  logic fetch_pending = 1'b0;
  logic [addr_width-1:0] fetch_addr = '0;
  int fetch_delay = 0;
  logic [desc_width-1:0] dispatched [$];
  int resp_q [$];
  int value_errors = 0;
  int other_errors = 0;
  logic timed_out = 1'b0;
  // set once a descriptor whose table row asks for an interrupt is written back
  logic irq_allowed = 1'b0;
  int wb_index = 0;

  desc_frontend desc_frontend_i (.*);

  always #50 clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [addr_width-1:0] desc_addr(input int i);
    return base_addr + addr_width'(i * desc_bytes);
  endfunction

  // owned, optional irq, a fixed tag in bits 23:16 and a junk byte where the error goes
  function automatic logic [word_width-1:0] control_word(input int i);
    logic [word_width-1:0] ctl;
    ctl = 32'h003c_0000;
    ctl[owned_bit] = 1'b1;
    ctl[irq_bit] = tbl_irq[i];
    ctl[error_lsb +: error_width] = 8'hc0 | 8'(i);
    return ctl;
  endfunction

  function automatic logic [desc_width-1:0] stored_desc(input int i);
    logic [desc_width-1:0] d;
    d = '0;
    d[src_lsb +: word_width] = tbl_source[i];
    d[dst_lsb +: word_width] = tbl_dest[i];
    d[len_lsb +: word_width] = tbl_length[i];
    d[ctl_lsb +: word_width] = control_word(i);
    return d;
  endfunction

  // returned to the host: actual count as length, ownership given back, error code in
  function automatic logic [desc_width-1:0] written_back(input int i);
    logic [desc_width-1:0] d;
    logic [word_width-1:0] ctl;
    ctl = control_word(i);
    ctl[owned_bit] = 1'b0;
    ctl[error_lsb +: error_width] = tbl_error[i];
    d = stored_desc(i);
    d[len_lsb +: word_width] = tbl_actual[i];
    d[ctl_lsb +: word_width] = ctl;
    return d;
  endfunction

  // unwritten words carry their own address and are never owned
  function automatic logic [desc_width-1:0] read_mem(input logic [addr_width-1:0] addr);
    if (mem.exists(addr))
    begin
      return mem[addr];
    end
    return {{(desc_width-addr_width){1'b0}}, addr};
  endfunction

  // ********************
  // compare tasks
  // ********************

  task automatic check_word(input string name, input logic [word_width-1:0] actual,
                            input logic [word_width-1:0] expected);
    if (actual !== expected)
    begin
      value_errors++;
      $display("ERR %s got %h expected %h", name, actual, expected);
    end
  endtask

  task automatic check_desc(input string name, input logic [desc_width-1:0] actual,
                            input logic [desc_width-1:0] expected);
    if (actual !== expected)
    begin
      value_errors++;
      $display("ERR %s got %h expected %h", name, actual, expected);
    end
  endtask

  task automatic check_csr(input string name, input logic [csr_data_width-1:0] actual,
                           input logic [csr_data_width-1:0] expected);
    if (actual !== expected)
    begin
      value_errors++;
      $display("ERR %s got %h expected %h", name, actual, expected);
    end
  endtask

  task automatic check_fetch_state(input string name, input fetch_state_t actual,
                                   input fetch_state_t expected);
    if (actual !== expected)
    begin
      value_errors++;
      $display("ERR %s got %h expected %h", name, actual, expected);
    end
  endtask

  task automatic check_bit(input string name, input logic actual, input logic expected);
    if (actual !== expected)
    begin
      value_errors++;
      $display("ERR %s got %h expected %h", name, actual, expected);
    end
  endtask

  // ********************
  // memory and stall model
  // ********************

  always @(posedge clk)
  begin
    lcg_state = lcg_next(lcg_state);
    if (reset)
    begin
      for (int i = 0; i < n_desc; i++)
      begin
        mem[desc_addr(i)] = stored_desc(i);
      end
      mem[desc_addr(n_desc)] = chain_end;
      wb_count = 0;
      irq_allowed = 1'b0;
      fetch_pending = 1'b0;
      m_fetch_readdatavalid <= 1'b0;
      m_fetch_waitrequest <= 1'b0;
      m_store_waitrequest <= 1'b0;
      src_ready <= 1'b0;
    end
    else
    begin
      // irq may only rise after a descriptor that asks for it has come back
      if (!irq_allowed)
      begin
        check_bit("irq", irq, 1'b0);
      end
      if (m_store_write && !m_store_waitrequest)
      begin
        mem[m_store_address] = m_store_writedata;
        wb_count++;
        wb_index = int'((m_store_address - base_addr) / desc_bytes);
        if (m_store_address >= base_addr && wb_index < n_desc && tbl_irq[wb_index])
        begin
          irq_allowed = 1'b1;
        end
      end
      // read data returns after a random latency when stalls are on
      m_fetch_readdatavalid <= 1'b0;
      if (fetch_pending)
      begin
        if (fetch_delay == 0)
        begin
          m_fetch_readdatavalid <= 1'b1;
          m_fetch_readdata <= read_mem(fetch_addr);
          fetch_pending = 1'b0;
        end
        else
        begin
          fetch_delay--;
        end
      end
      if (m_fetch_read && !m_fetch_waitrequest)
      begin
        fetch_pending = 1'b1;
        fetch_addr = m_fetch_address;
        fetch_delay = stall_en ? int'(lcg_state[27:26]) : 0;
      end
      m_fetch_waitrequest <= stall_en && lcg_state[31];
      m_store_waitrequest <= stall_en && lcg_state[30];
      src_ready <= !stall_en || (lcg_state[29:28] != 2'b00);
    end
  end

  // dispatcher model, answers in order with the table's result for each descriptor
  always @(posedge clk)
  begin
    if (reset)
    begin
      dispatched.delete();
      resp_q.delete();
      snk_valid <= 1'b0;
    end
    else
    begin
      if (src_valid)
      begin
        dispatched.push_back({src_control, src_length, src_destination, src_source});
        resp_q.push_back(dispatched.size() - 1);
      end
      if (snk_valid && snk_ready)
      begin
        void'(resp_q.pop_front());
      end
      if (resp_q.size() != 0)
      begin
        snk_valid <= 1'b1;
        snk_actual_bytes <= tbl_actual[resp_q[0]];
        snk_error <= tbl_error[resp_q[0]];
      end
      else
      begin
        snk_valid <= 1'b0;
      end
    end
  end

  // ********************
  // host access and sequences
  // ********************

  task automatic csr_write(input csr_reg_t addr, input logic [csr_data_width-1:0] data,
                           input logic [7:0] be);
    s_address <= addr;
    s_writedata <= data;
    s_byteenable <= be;
    s_write <= 1'b1;
    @(posedge clk);
    s_write <= 1'b0;
  endtask

  // readdata is registered, so it is taken one edge after the read cycle
  task automatic csr_read(input csr_reg_t addr, output logic [csr_data_width-1:0] data);
    s_address <= addr;
    s_read <= 1'b1;
    @(posedge clk);
    s_read <= 1'b0;
    @(posedge clk);
    data = s_readdata;
  endtask

  task automatic apply_reset();
    reset <= 1'b1;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
  endtask

  // polls status until both engines are idle and every descriptor came back
  task automatic wait_chain_done();
    logic [csr_data_width-1:0] status;
    int cycles;
    status = '0;
    cycles = 0;
    while (!(wb_count == n_desc && status[2:1] == 2'b11) && cycles < wait_limit)
    begin
      csr_read(reg_status, status);
      cycles += 2;
    end
    if (!(wb_count == n_desc && status[2:1] == 2'b11))
    begin
      timed_out = 1'b1;
      other_errors++;
      $display("timeout: descriptor chain not complete after %0d cycles, %0d written back",
               cycles, wb_count);
    end
  endtask

  task automatic check_register_defaults();
    logic [csr_data_width-1:0] data;
    csr_read(reg_status, data);
    // both engines idle and no interrupt pending
    check_csr("reg_status", data, 64'h6);
    check_bit("irq", irq, 1'b0);
    csr_write(reg_control, {csr_data_width{1'b1}}, 8'hff);
    csr_read(reg_control, data);
    check_csr("reg_control", data, 64'h5);
    csr_write(reg_control, '0, 8'hff);
    csr_read(csr_reg_t'(3'd7), data);
    check_csr("unused offset", data, '0);
  endtask

  task automatic run_chain(input logic stalls, input logic mask);
    logic [csr_data_width-1:0] data;
    logic [csr_data_width-1:0] end_loc;
    stall_en = stalls;
    // reset also reloads the table into memory
    apply_reset();
    end_loc = csr_data_width'(desc_addr(n_desc));
    csr_write(reg_control, mask ? 64'h5 : 64'h1, 8'hff);
    csr_write(reg_start, csr_data_width'(base_addr), 8'hff);
    wait_chain_done();
    if (timed_out)
    begin
      return;
    end
    check_word("dispatch count", 32'(dispatched.size()), 32'(n_desc));
    for (int i = 0; i < n_desc && i < dispatched.size(); i++)
    begin
      check_word("src_source", dispatched[i][src_lsb +: word_width], tbl_source[i]);
      check_word("src_destination", dispatched[i][dst_lsb +: word_width], tbl_dest[i]);
      check_word("src_length", dispatched[i][len_lsb +: word_width], tbl_length[i]);
      check_word("src_control", dispatched[i][ctl_lsb +: word_width], control_word(i));
    end
    for (int i = 0; i < n_desc; i++)
    begin
      check_desc("writeback", read_mem(desc_addr(i)), written_back(i));
    end
    // the unowned word stops the chain and is left untouched
    check_desc("chain end word", read_mem(desc_addr(n_desc)), chain_end);
    csr_read(reg_fetch_loc, data);
    check_csr("reg_fetch_loc", data, end_loc);
    csr_read(reg_store_loc, data);
    check_csr("reg_store_loc", data, end_loc);
    csr_read(reg_status, data);
    check_fetch_state("fetch_state", fetch_state_t'(data[10:8]), f_idle);
    check_csr("reg_status", data, 64'h7);
    // irq follows the status bit only while unmasked
    check_bit("irq", irq, mask);
    csr_write(reg_status, 64'h1, 8'h01);
    @(posedge clk);
    check_bit("irq", irq, 1'b0);
    csr_read(reg_status, data);
    check_csr("reg_status", data, 64'h6);
  endtask

  initial
  begin
    apply_reset();
    check_register_defaults();
    // first chain runs without stalls and with the interrupt unmasked
    run_chain(1'b0, 1'b1);
    if (!timed_out)
    begin
      run_chain(1'b1, 1'b0);
    end
    $display("%0d value errors, %0d other errors", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0)
    begin
      $display("SIMULATION PASSED");
    end
    else
    begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
